// ==== rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0100

// register index fields, each 5 bits wide
`define RV_RS1_LSB 15
`define RV_RS2_LSB 20
`define RV_RD_LSB  7

`endif

// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    LUI    = 7'b0110111,
    SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_PASS_B // lui passes the immediate straight through
  } alu_op_t;

  typedef enum logic [2:0] {
    CLS_R, CLS_I, CLS_LOAD, CLS_STORE, CLS_BRANCH, CLS_LUI, CLS_HALT, CLS_ILLEGAL
  } instr_class_t;

  typedef enum logic [3:0] {
    FETCH, FETCH_WAIT, DECODE, EXECUTE, MEM, MEM_WAIT, WRITEBACK, HALT
  } ctrl_state_t;

  // four-phase master states
  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_REQ,     // req high, waiting for ack
    PORT_RELEASE  // req dropped, waiting for ack to fall
  } port_state_t;

endpackage

`default_nettype wire

// ==== rv_mem_if.sv ====
`default_nettype none

// one memory access between the controller and the four-phase port
interface rv_mem_if;
  logic        start;  // single-cycle request pulse
  logic        we;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [31:0] rdata;  // valid from done until the next start
  logic        done;   // single-cycle completion pulse

  modport ctrl (output start, we, addr, wdata, input rdata, done);
  modport port (input start, we, addr, wdata, output rdata, done);
endinterface

`default_nettype wire

// ==== rv_decoder.sv ====
`default_nettype none

`include "rv_cfg.svh"

module rv_decoder import rv_pkg::*; (
  input  logic [31:0]  instr,
  output instr_class_t cls,
  output alu_op_t      alu_op,
  output logic [4:0]   rs1,
  output logic [4:0]   rs2,
  output logic [4:0]   rd,
  output logic [31:0]  imm,
  output logic         branch_ne
);

  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        shift_ok; // funct7 legal for a shift-right style encoding
  logic [31:0] imm_i, imm_s, imm_b, imm_u;

  // funct3 picks the operation, alt selects sub / sra
  function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign funct3    = instr[14:12];
  assign funct7    = instr[31:25];
  assign shift_ok  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
  assign rs1       = instr[`RV_RS1_LSB +: 5];
  assign rs2       = instr[`RV_RS2_LSB +: 5];
  assign rd        = instr[`RV_RD_LSB +: 5];
  assign branch_ne = funct3[0]; // beq 000, bne 001

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  always_comb begin
    cls    = CLS_ILLEGAL;
    alu_op = ALU_ADD;
    imm    = imm_i;
    case (instr[6:0])
      OP: begin
        alu_op = arith_op(funct3, funct7[5]);
        if (funct7 == 7'b0000000 || (shift_ok && (funct3 == 3'b000 || funct3 == 3'b101)))
          cls = CLS_R;
      end
      OP_IMM: begin
        alu_op = arith_op(funct3, funct7[5] && funct3 == 3'b101); // addi has no subtract
        if (funct3 == 3'b001)
          cls = (funct7 == 7'b0000000) ? CLS_I : CLS_ILLEGAL;
        else if (funct3 == 3'b101)
          cls = shift_ok ? CLS_I : CLS_ILLEGAL;
        else if (funct3 != 3'b011) // no sltiu here
          cls = CLS_I;
      end
      LOAD:   if (funct3 == 3'b010) cls = CLS_LOAD; // word only
      STORE: begin
        imm = imm_s;
        if (funct3 == 3'b010) cls = CLS_STORE;
      end
      BRANCH: begin
        alu_op = ALU_SUB;
        imm    = imm_b;
        if (funct3[2:1] == 2'b00) cls = CLS_BRANCH;
      end
      LUI: begin
        alu_op = ALU_PASS_B;
        imm    = imm_u;
        cls    = CLS_LUI;
      end
      SYSTEM: if (instr == 32'h0010_0073) cls = CLS_HALT; // ebreak
      default: cls = CLS_ILLEGAL;
    endcase
  end

endmodule

`default_nettype wire

// ==== rv_alu.sv ====
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  alu_op_t     op,
  output logic [31:0] result,
  output logic        eq
);

  logic [4:0] shamt;

  assign shamt = b[4:0];
  assign eq    = (a == b); // branch compare

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      ALU_SLL:    result = a << shamt;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
      ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU:   result = {31'b0, a < b};
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
`default_nettype none

module rv_regfile (
  input  logic        clk,
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [4:0]  raddr0,
  input  logic [4:0]  raddr1,
  input  logic [31:0] wdata,
  output logic [31:0] rdata0,
  output logic [31:0] rdata1
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (we && waddr != 5'd0) regs[waddr] <= wdata; // x0 stays zero
  end

  // asynchronous reads
  assign rdata0 = (raddr0 == 5'd0) ? 32'd0 : regs[raddr0];
  assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];

endmodule

`default_nettype wire

// ==== rv_mem_port.sv ====
`default_nettype none

module rv_mem_port import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  rv_mem_if.port      bus,
  output logic        mem_req,
  output logic        mem_we,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata,
  input  logic        mem_ack,
  input  logic [31:0] mem_rdata
);

  port_state_t state;
  logic        done_q;
  logic [31:0] rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= PORT_IDLE;
      mem_req <= 1'b0;
      mem_we  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        PORT_IDLE: if (bus.start) begin
          mem_req <= 1'b1;
          mem_we  <= bus.we;
          state   <= PORT_REQ;
        end
        PORT_REQ: if (mem_ack) begin
          mem_req <= 1'b0; // phase 2 seen, release
          state   <= PORT_RELEASE;
        end
        PORT_RELEASE: if (!mem_ack) begin
          mem_we <= 1'b0;
          done_q <= 1'b1;
          state  <= PORT_IDLE;
        end
        default: state <= PORT_IDLE;
      endcase
    end
  end

  // address and data follow the request, read data held past done
  always_ff @(posedge clk) begin
    if (state == PORT_IDLE && bus.start) begin
      mem_addr  <= bus.addr;
      mem_wdata <= bus.wdata;
    end
    if (state == PORT_REQ && mem_ack) rdata_q <= mem_rdata;
  end

  assign bus.rdata = rdata_q;
  assign bus.done  = done_q;

endmodule

`default_nettype wire

// ==== rv_control.sv ====
`default_nettype none

`include "rv_cfg.svh"

module rv_control import rv_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  rv_mem_if.ctrl       mem,
  output logic [31:0]  instr,
  input  instr_class_t cls,
  input  alu_op_t      alu_op,
  input  logic [31:0]  imm,
  input  logic [31:0]  rs1_data,
  input  logic [31:0]  rs2_data,
  output logic [31:0]  alu_a,
  output logic [31:0]  alu_b,
  input  logic [31:0]  alu_result,
  input  logic         alu_eq,
  input  logic         branch_ne,
  output logic         rf_we,
  output logic [31:0]  rf_wdata,
  output logic         halted,
  output logic [31:0]  pc
);

  ctrl_state_t state;
  logic        taken;     // branch outcome from EXECUTE
  logic [31:0] instr_q;
  logic [31:0] opa_q, opb_q;
  logic [31:0] store_q;   // rs2 value for sw
  logic [31:0] result_q;
  logic [31:0] load_q;
  logic        is_mem;

  assign is_mem = (cls == CLS_LOAD) || (cls == CLS_STORE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FETCH;
      pc    <= `RV_RESET_PC;
      taken <= 1'b0;
    end else begin
      case (state)
        FETCH:      state <= FETCH_WAIT;
        FETCH_WAIT: if (mem.done) state <= DECODE;
        DECODE: begin
          if (cls == CLS_HALT || cls == CLS_ILLEGAL) state <= HALT;
          else state <= EXECUTE;
        end
        EXECUTE: begin
          taken <= (cls == CLS_BRANCH) && (alu_eq ^ branch_ne);
          state <= is_mem ? MEM : WRITEBACK;
        end
        MEM:      state <= MEM_WAIT;
        MEM_WAIT: if (mem.done) state <= WRITEBACK;
        WRITEBACK: begin
          pc    <= taken ? pc + imm : pc + 32'd4;
          taken <= 1'b0;
          state <= FETCH;
        end
        HALT:    state <= HALT; // only reset leaves
        default: state <= HALT;
      endcase
    end
  end

  // datapath registers
  always_ff @(posedge clk) begin
    case (state)
      FETCH_WAIT: if (mem.done) instr_q <= mem.rdata;
      DECODE: begin
        opa_q   <= rs1_data;
        opb_q   <= (cls == CLS_R || cls == CLS_BRANCH) ? rs2_data : imm;
        store_q <= rs2_data;
      end
      EXECUTE:  result_q <= alu_result; // also the load/store address
      MEM_WAIT: if (mem.done) load_q <= mem.rdata;
      default: ;
    endcase
  end

  // memory request, address held until done
  assign mem.start = (state == FETCH) || (state == MEM);
  assign mem.we    = (state == MEM || state == MEM_WAIT) && (cls == CLS_STORE);
  assign mem.addr  = (state == MEM || state == MEM_WAIT) ? result_q : pc;
  assign mem.wdata = store_q;

  assign instr    = instr_q;
  assign alu_a    = opa_q;
  assign alu_b    = opb_q;
  assign rf_we    = (state == WRITEBACK) && (cls != CLS_STORE) && (cls != CLS_BRANCH);
  assign rf_wdata = (cls == CLS_LOAD) ? load_q : result_q;
  assign halted   = (state == HALT);

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  output logic        mem_req,
  output logic        mem_we,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata,
  input  logic        mem_ack,
  input  logic [31:0] mem_rdata,
  output logic        halted,
  output logic [31:0] pc
);

  rv_mem_if mem_bus ();

  instr_class_t cls;
  alu_op_t      alu_op;
  logic [31:0]  instr, imm, rs1_data, rs2_data;
  logic [31:0]  alu_a, alu_b, alu_result, rf_wdata;
  logic [4:0]   rs1, rs2, rd;
  logic         alu_eq, branch_ne, rf_we;

  rv_control u_control (
    .clk(clk), .rst(rst), .mem(mem_bus), .instr(instr),
    .cls(cls), .alu_op(alu_op), .imm(imm),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .alu_a(alu_a), .alu_b(alu_b), .alu_result(alu_result), .alu_eq(alu_eq),
    .branch_ne(branch_ne), .rf_we(rf_we), .rf_wdata(rf_wdata),
    .halted(halted), .pc(pc)
  );

  rv_decoder u_decoder (
    .instr(instr), .cls(cls), .alu_op(alu_op),
    .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .branch_ne(branch_ne)
  );

  rv_alu u_alu (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result), .eq(alu_eq));

  rv_regfile u_regfile (
    .clk(clk), .we(rf_we), .waddr(rd), .raddr0(rs1), .raddr1(rs2),
    .wdata(rf_wdata), .rdata0(rs1_data), .rdata1(rs2_data)
  );

  rv_mem_port u_mem_port (
    .clk(clk), .rst(rst), .bus(mem_bus),
    .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata)
  );

endmodule

`default_nettype wire

// ==== rv_core_assertions.sv ====
`default_nettype none

module rv_core_assertions (
  input logic        clk,
  input logic        rst,
  input logic        mem_req,
  input logic        mem_ack,
  input logic [31:0] mem_addr,
  input logic        halted
);

  // four-phase, req stays up until the memory answers
  req_held: assert property (@(posedge clk) disable iff (rst)
    mem_req && !mem_ack |=> mem_req)
    else $error("mem_req fell before mem_ack rose");

  addr_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req && $past(mem_req) |-> $stable(mem_addr))
    else $error("mem_addr changed while mem_req was high");

  no_req_halted: assert property (@(posedge clk) disable iff (rst)
    halted |-> !mem_req)
    else $error("mem_req raised while halted");

endmodule

bind rv_core rv_core_assertions u_assertions (
  .clk(clk), .rst(rst), .mem_req(mem_req), .mem_ack(mem_ack),
  .mem_addr(mem_addr), .halted(halted)
);

`default_nettype wire

// ==== tb_rv_core.sv ====
`default_nettype none

`include "rv_cfg.svh"

module tb_rv_core;

  logic        clk;
  logic        rst;
  logic        mem_req, mem_we, halted;
  logic [31:0] mem_addr, mem_wdata, pc;
  logic        mem_ack = 1'b0;
  logic [31:0] mem_rdata = 32'd0;
  logic        req_q = 1'b0;
  logic [1:0]  wait_cnt = 2'd0;   // ack delay of the current access
  integer      seed = 32'h32dfbd83;
  logic [31:0] image [1024];       // program and data loaded at reset
  logic [31:0] mem [1024];
  logic [31:0] ref_mem [1024];
  logic [31:0] ptr;
  logic [31:0] halt_pc;            // address of the ebreak
  logic        exp_we [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];

  rv_core u_rv_core (
    .clk(clk), .rst(rst), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
    .halted(halted), .pc(pc)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_sim();
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_run(input string why);
    $display("%s at time %0t", why, $time);
    stop_sim();
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR time=%0t %s got=%h expected=%h", $time, name, got, exp);
      stop_sim();
    end
  endtask

  // generic field packing, hi = funct7 or imm[11:5], lo = rd or imm[4:0]
  function automatic logic [31:0] encode(input logic [6:0] hi, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] lo, input logic [6:0] op);
    return {hi, 25'd0} | (32'(rs2) << `RV_RS2_LSB) | (32'(rs1) << `RV_RS1_LSB)
           | (32'(f3) << 12) | (32'(lo) << `RV_RD_LSB) | 32'(op);
  endfunction

  task automatic emit(input logic [31:0] w);
    image[ptr[11:2]] = w;
    ptr = ptr + 32'd4;
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] c);
    logic [31:0] hi;
    hi = c + 32'h800; // addi sign-extends the low twelve bits
    emit({hi[31:12], rd, 7'b0110111});
    emit(encode(c[11:5], c[4:0], rd, 3'd0, rd, 7'b0010011));
  endtask

  // sw rs2, off(x10)
  task automatic store_word(input logic [4:0] rs2, input logic [11:0] off);
    emit(encode(off[11:5], rs2, 5'd10, 3'd2, off[4:0], 7'b0100011));
  endtask

  task automatic gen_program();
    logic [10:0] i;
    logic [11:0] off;
    logic [31:0] imm;
    logic [2:0]  f3;
    int          k;
    for (i = 0; i < 11'd1024; i++) image[i[9:0]] = 32'h5a00_0000 | {20'd0, i[9:0], 2'd0};
    ptr = `RV_RESET_PC;
    off = 12'd0;
    load_const(5'd1, $random(seed) & 32'h7fff_ffff);
    load_const(5'd2, $random(seed) | 32'h8000_0000); // negative operand
    load_const(5'd10, 32'h0000_0800);                // store area
    for (k = 0; k < 10; k++) begin // sub and sra come last
      f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
      emit(encode((k >= 8) ? 7'h20 : 7'h00, 5'd1, 5'd2, f3, 5'd3, 7'b0110011));
      store_word(5'd3, off);
      off = off + 12'd4;
    end
    for (k = 0; k < 9; k++) begin
      if (k == 3) continue; // no sltiu in this core
      f3 = (k < 8) ? 3'(k) : 3'd5;
      imm = $random(seed);
      if (f3 == 3'd1 || f3 == 3'd5) imm[11:5] = (k == 8) ? 7'h20 : 7'h00;
      emit(encode(imm[11:5], imm[4:0], 5'd2, f3, 5'd3, 7'b0010011));
      store_word(5'd3, off);
      off = off + 12'd4;
    end
    emit(encode(7'd0, 5'd0, 5'd10, 3'd2, 5'd4, 7'b0000011)); // lw x4, 0(x10)
    store_word(5'd4, off);
    off = off + 12'd4;
    // each branch jumps +8 over one addi into x5
    emit(encode(7'd0, 5'd2, 5'd1, 3'd0, 5'b01000, 7'b1100011)); // beq, not taken
    emit(encode(7'd0, 5'd1, 5'd0, 3'd0, 5'd5, 7'b0010011));
    emit(encode(7'd0, 5'd2, 5'd1, 3'd1, 5'b01000, 7'b1100011)); // bne, taken
    emit(encode(7'd0, 5'd2, 5'd5, 3'd0, 5'd5, 7'b0010011));
    emit(encode(7'd0, 5'd1, 5'd1, 3'd0, 5'b01000, 7'b1100011)); // beq, taken
    emit(encode(7'd0, 5'd4, 5'd5, 3'd0, 5'd5, 7'b0010011));
    emit(encode(7'd0, 5'd1, 5'd1, 3'd1, 5'b01000, 7'b1100011)); // bne, not taken
    emit(encode(7'd0, 5'd8, 5'd5, 3'd0, 5'd5, 7'b0010011));
    store_word(5'd5, off);
    emit(32'h0010_0073); // ebreak
  endtask

  function automatic logic [31:0] isa_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $unsigned($signed(a) >>> b[4:0]);
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic void expect_access(input logic we, input logic [31:0] addr,
                                        input logic [31:0] data);
    exp_we.push_back(we);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endfunction

  // instruction-level model, fills the expected access queues and ref_mem
  function automatic void run_reference();
    logic [31:0] x [32];
    logic [31:0] ir, pc_r, a, b, ea, next_pc;
    logic [2:0]  f3;
    logic [4:0]  rd;
    int          steps, r;
    for (r = 0; r < 32; r++) x[r] = 32'd0;
    pc_r = `RV_RESET_PC;
    for (steps = 0; steps < 1000; steps++) begin
      ir = ref_mem[pc_r[11:2]];
      expect_access(1'b0, pc_r, 32'd0);
      halt_pc = pc_r;
      if (ir == 32'h0010_0073) break;
      f3 = ir[14:12];
      rd = ir[`RV_RD_LSB +: 5];
      a = x[ir[`RV_RS1_LSB +: 5]];
      b = x[ir[`RV_RS2_LSB +: 5]];
      next_pc = pc_r + 32'd4;
      case (ir[6:0])
        7'b0110011: x[rd] = isa_alu(f3, ir[30], a, b);
        7'b0010011: x[rd] = isa_alu(f3, ir[30] && f3 == 3'd5, a, {{20{ir[31]}}, ir[31:20]});
        7'b0000011: begin
          ea = a + {{20{ir[31]}}, ir[31:20]};
          expect_access(1'b0, ea, 32'd0);
          x[rd] = ref_mem[ea[11:2]];
        end
        7'b0100011: begin
          ea = a + {{20{ir[31]}}, ir[31:25], ir[11:7]};
          expect_access(1'b1, ea, b);
          ref_mem[ea[11:2]] = b;
        end
        7'b1100011: if ((a == b) != ir[12])
          next_pc = pc_r + {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
        7'b0110111: x[rd] = {ir[31:12], 12'd0};
        default: ;
      endcase
      x[0] = 32'd0;
      pc_r = next_pc;
    end
  endfunction

  // memory model, ack after 0 to 3 cycles
  always @(posedge clk) begin
    if (rst) begin
      mem      <= image;
      mem_ack  <= 1'b0;
      wait_cnt <= 2'd0;
    end else if (mem_req && !mem_ack) begin
      if (wait_cnt != 2'd0) begin
        wait_cnt <= wait_cnt - 2'd1;
      end else begin
        if (mem_we) mem[mem_addr[11:2]] <= mem_wdata;
        else mem_rdata <= mem[mem_addr[11:2]];
        mem_ack <= 1'b1;
      end
    end else if (!mem_req && mem_ack) begin
      mem_ack  <= 1'b0;
      wait_cnt <= 2'($random(seed));
    end
  end

  // compare each new request with the reference sequence
  always @(posedge clk) begin
    req_q <= mem_req;
    if (!rst && mem_req && !req_q) begin
      if (exp_we.size() == 0) begin
        abort_run("memory request beyond the end of the reference program");
      end else begin
        compare_value("mem_we", 32'(mem_we), 32'(exp_we.pop_front()));
        compare_value("mem_addr", mem_addr, exp_addr.pop_front());
        if (mem_we) compare_value("mem_wdata", mem_wdata, exp_data.pop_front());
        else void'(exp_data.pop_front());
      end
    end
  end

  initial begin
    int          cycles;
    logic [10:0] i;
    rst = 1'b1;
    gen_program();
    ref_mem = image;
    run_reference();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    compare_value("mem_req", 32'(mem_req), 32'd0);
    compare_value("halted", 32'(halted), 32'd0);
    compare_value("pc", pc, `RV_RESET_PC);
    cycles = 0;
    while (!halted) begin
      @(posedge clk);
      cycles++;
      if (cycles > 20000) abort_run($sformatf("core did not halt, pc %h", pc));
    end
    if (exp_we.size() != 0) abort_run("core halted before the reference program ended");
    compare_value("pc", pc, halt_pc); // stays on the ebreak
    repeat (50) begin
      @(posedge clk);
      compare_value("mem_req", 32'(mem_req), 32'd0); // halt stays quiet
    end
    for (i = 0; i < 11'd1024; i++)
      compare_value($sformatf("mem[%h]", {i[9:0], 2'b00}), mem[i[9:0]], ref_mem[i[9:0]]);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
rv_pkg.sv
rv_mem_if.sv
rv_decoder.sv
rv_alu.sv
rv_regfile.sv
rv_mem_port.sv
rv_control.sv
rv_core.sv
rv_core_assertions.sv
tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_rv_core -Mdir obj_dir
./obj_dir/Vtb_rv_core 2>&1 | tee sim.log
if grep -qx "TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
